// File: source/bp_pkg.sv
package bp_pkg;

    // table geometry
    localparam int ASSOCIATIVITY = 2;
    localparam int SET_NUM = 16;
    localparam int INDEX_BITS = 4;
    localparam int WAY_BITS = 1;
    localparam int TAG_BITS = 18;
    localparam int COUNTER_BITS = 2;

    // pc field positions, word aligned
    localparam int TAG_LSB = 2;
    localparam int INDEX_LSB = 4;

    typedef logic [31:0] addr_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [COUNTER_BITS-1:0] counter_t;

    // saturation limits of the direction counter
    localparam counter_t COUNTER_MAX = '1;
    localparam counter_t COUNTER_MIN = '0;

    // one way of a metadata row
    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    // full metadata row, all ways of a set
    typedef meta_t [ASSOCIATIVITY-1:0] meta_set_t;

    // address into target and counter tables
    typedef struct packed {
        index_t index;
        way_t way;
    } ram_addr_t;

    typedef struct packed {
        addr_t pc;
    } lookup_req_t;

    typedef struct packed {
        logic hit;
        logic hit_pc;
        logic hit_pcp4;
        logic taken;
        addr_t target;
    } lookup_rsp_t;

    // resolved branch from execute
    typedef struct packed {
        logic valid;
        addr_t pc;
        logic taken;
        addr_t dest;
    } update_req_t;

    // tag spans the index bits too
    function automatic tag_t tag_of(addr_t pc);
        return pc[TAG_LSB+TAG_BITS-1:TAG_LSB];
    endfunction

    function automatic index_t index_of(addr_t pc);
        return pc[INDEX_LSB+INDEX_BITS-1:INDEX_LSB];
    endfunction

endpackage

// File: source/lutram_dual_port.sv
`timescale 1ns/1ps

module lutram_dual_port #(
    parameter type payload_t = logic,
    parameter int DEPTH = 16
) (
    input logic clk,

    // port 1, read and write
    input logic we1,
    input logic [$clog2(DEPTH)-1:0] addr1,
    input payload_t wdata1,
    output payload_t rdata1,

    // port 2, read only
    input logic [$clog2(DEPTH)-1:0] addr2,
    output payload_t rdata2
);

    // distributed ram storage
    // contents come only from writes through port 1
    payload_t mem [DEPTH];

    // zero latency reads on both ports
    // a read shows the value from before the current edge
    assign rdata1 = mem[addr1];
    assign rdata2 = mem[addr2];

    // single clocked write port
    always_ff @(posedge clk) begin
        if (we1) begin
            mem[addr1] <= wdata1;
        end
    end

endmodule

// File: source/plru_state.sv
`timescale 1ns/1ps

module plru_state (
    input logic clk,
    input logic arst_n,

    // lookup hit
    input logic touch,
    input bp_pkg::index_t touch_index,
    input bp_pkg::way_t touch_way,

    // sweep clear
    input logic clear,
    input bp_pkg::index_t clear_index,

    // replacement choice for the update set
    input bp_pkg::index_t victim_index,
    output bp_pkg::way_t victim
);

    // one bit per set, two ways only
    logic [bp_pkg::SET_NUM-1:0] lru_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (clear) begin
            lru_bits[clear_index] <= 1'b0;
        end else if (touch) begin
            // point at the way not just used
            lru_bits[touch_index] <= ~touch_way;
        end
    end

    // stored bit names the way to evict
    assign victim = bp_pkg::way_t'(lru_bits[victim_index]);

endmodule

// File: source/btb_lookup.sv
`timescale 1ns/1ps

module btb_lookup (
    input bp_pkg::lookup_req_t lookup,
    input logic ready,

    // metadata row of the pc's set
    input bp_pkg::meta_set_t meta_row,
    output bp_pkg::index_t meta_index,

    // target and counter of the winning way
    output bp_pkg::ram_addr_t pred_addr,
    input bp_pkg::addr_t target,
    input bp_pkg::counter_t counter,

    output bp_pkg::lookup_rsp_t response,

    // replacement touch toward plru
    output logic touch,
    output bp_pkg::index_t touch_index,
    output bp_pkg::way_t touch_way
);

    bp_pkg::tag_t pc_tag;
    bp_pkg::tag_t pcp4_tag;
    logic pc_match;
    logic pcp4_match;
    bp_pkg::way_t pc_way;
    bp_pkg::way_t pcp4_way;
    logic hit;
    bp_pkg::way_t hit_way;

    // pc+4 shares the set whenever its tag can match
    assign pc_tag = bp_pkg::tag_of(lookup.pc);
    assign pcp4_tag = bp_pkg::tag_of(lookup.pc + 32'd4);
    assign meta_index = bp_pkg::index_of(lookup.pc);

    // tag compare across all valid ways
    always_comb begin
        pc_match = 1'b0;
        pcp4_match = 1'b0;
        pc_way = '0;
        pcp4_way = '0;
        for (int i = 0; i < bp_pkg::ASSOCIATIVITY; i++) begin
            if (meta_row[i].valid && meta_row[i].tag == pc_tag) begin
                pc_match = 1'b1;
                pc_way = bp_pkg::way_t'(i);
            end
            if (meta_row[i].valid && meta_row[i].tag == pcp4_tag) begin
                pcp4_match = 1'b1;
                pcp4_way = bp_pkg::way_t'(i);
            end
        end
    end

    // pc hit wins over pc+4 hit
    assign hit_way = pc_match ? pc_way : pcp4_way;
    // no hits while the sweep is running
    assign hit = ready & (pc_match | pcp4_match);

    assign pred_addr.index = meta_index;
    assign pred_addr.way = hit_way;

    assign response.hit = hit;
    assign response.hit_pc = ready & pc_match;
    assign response.hit_pcp4 = ready & ~pc_match & pcp4_match;
    // direction from counter msb, low on a miss
    assign response.taken = hit & counter[bp_pkg::COUNTER_BITS-1];
    assign response.target = hit ? target : '0;

    // hit way marks the set as recently used
    assign touch = hit;
    assign touch_index = meta_index;
    assign touch_way = hit_way;

endmodule

// File: source/btb_update.sv
`timescale 1ns/1ps

module btb_update (
    input logic clk,
    input logic arst_n,

    // resolved branch from execute
    input bp_pkg::update_req_t update,

    // metadata table, port 1
    input bp_pkg::meta_set_t meta_row,
    output logic meta_we,
    output bp_pkg::index_t meta_index,
    output bp_pkg::meta_set_t meta_wdata,

    // shared address of target and counter tables
    output bp_pkg::ram_addr_t ram_addr,
    input bp_pkg::counter_t counter_rd,
    output logic target_we,
    output bp_pkg::addr_t target_wdata,
    output logic counter_we,
    output bp_pkg::counter_t counter_wdata,

    // replacement
    input bp_pkg::way_t victim,
    output bp_pkg::index_t victim_index,

    // sweep toward plru
    output logic clear,
    output bp_pkg::index_t clear_index,

    output logic ready
);

    bp_pkg::index_t sweep_index;
    bp_pkg::index_t upd_index;
    bp_pkg::tag_t upd_tag;
    logic in_table;
    bp_pkg::way_t in_way;
    logic alloc;
    logic step;
    bp_pkg::counter_t stepped;

    // sweep one set per cycle after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_index <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_index == bp_pkg::index_t'(bp_pkg::SET_NUM - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    assign upd_index = bp_pkg::index_of(update.pc);
    assign upd_tag = bp_pkg::tag_of(update.pc);

    // search executed branch in its set
    always_comb begin
        in_table = 1'b0;
        in_way = '0;
        for (int i = 0; i < bp_pkg::ASSOCIATIVITY; i++) begin
            if (meta_row[i].valid && meta_row[i].tag == upd_tag) begin
                in_table = 1'b1;
                in_way = bp_pkg::way_t'(i);
            end
        end
    end

    // taken miss allocates, known branch steps
    // not taken miss drops out here
    assign alloc = ready & update.valid & update.taken & ~in_table;
    assign step = ready & update.valid & in_table;

    // 2-bit saturating counter
    always_comb begin
        if (update.taken) begin
            stepped = (counter_rd == bp_pkg::COUNTER_MAX) ? counter_rd : counter_rd + 1'b1;
        end else begin
            stepped = (counter_rd == bp_pkg::COUNTER_MIN) ? counter_rd : counter_rd - 1'b1;
        end
    end

    // metadata port follows the sweep until ready
    assign meta_index = ready ? upd_index : sweep_index;
    assign meta_we = ~ready | alloc;

    // victim way gets the new tag, other ways kept
    always_comb begin
        meta_wdata = meta_row;
        if (!ready) begin
            meta_wdata = '0;
        end else begin
            meta_wdata[victim].valid = 1'b1;
            meta_wdata[victim].tag = upd_tag;
        end
    end

    // data side of an invalid way is never read out
    // allocation rewrites target and counter together
    always_comb begin
        if (!ready) begin
            ram_addr.index = sweep_index;
            ram_addr.way = '0;
        end else begin
            ram_addr.index = upd_index;
            ram_addr.way = in_table ? in_way : victim;
        end
    end

    assign target_we = ~ready | alloc;
    assign target_wdata = ready ? update.dest : '0;

    // new entries start strongly taken
    assign counter_we = ~ready | alloc | step;
    assign counter_wdata = (ready && in_table) ? stepped : bp_pkg::COUNTER_MAX;

    // plru bit read at the update set
    assign victim_index = upd_index;

    assign clear = ~ready;
    assign clear_index = sweep_index;

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input logic clk,
    input logic arst_n,
    input bp_pkg::lookup_req_t lookup,
    input bp_pkg::update_req_t update,
    output bp_pkg::lookup_rsp_t response,
    output logic ready
);

    // metadata table wires
    bp_pkg::meta_set_t upd_meta_row;
    bp_pkg::meta_set_t lk_meta_row;
    logic meta_we;
    bp_pkg::index_t upd_meta_index;
    bp_pkg::index_t lk_meta_index;
    bp_pkg::meta_set_t meta_wdata;

    // target and counter table wires
    bp_pkg::ram_addr_t upd_ram_addr;
    bp_pkg::ram_addr_t pred_addr;
    logic target_we;
    bp_pkg::addr_t target_wdata;
    bp_pkg::addr_t pred_target;
    logic counter_we;
    bp_pkg::counter_t counter_wdata;
    bp_pkg::counter_t upd_counter;
    bp_pkg::counter_t pred_counter;

    // plru wires
    logic touch;
    bp_pkg::index_t touch_index;
    bp_pkg::way_t touch_way;
    logic clear;
    bp_pkg::index_t clear_index;
    bp_pkg::index_t victim_index;
    bp_pkg::way_t victim;

    // valid and tag per way, one row per set
    lutram_dual_port #(.payload_t(bp_pkg::meta_set_t), .DEPTH(bp_pkg::SET_NUM)) u_meta_ram (
        .clk(clk), .we1(meta_we), .addr1(upd_meta_index), .wdata1(meta_wdata),
        .rdata1(upd_meta_row), .addr2(lk_meta_index), .rdata2(lk_meta_row)
    );

    // branch targets, written on allocation only
    lutram_dual_port #(
        .payload_t(bp_pkg::addr_t),
        .DEPTH(bp_pkg::SET_NUM * bp_pkg::ASSOCIATIVITY)
    ) u_target_ram (
        .clk(clk), .we1(target_we), .addr1(upd_ram_addr), .wdata1(target_wdata),
        .rdata1(), .addr2(pred_addr), .rdata2(pred_target)
    );

    // direction counters, read back for the step
    lutram_dual_port #(
        .payload_t(bp_pkg::counter_t),
        .DEPTH(bp_pkg::SET_NUM * bp_pkg::ASSOCIATIVITY)
    ) u_counter_ram (
        .clk(clk), .we1(counter_we), .addr1(upd_ram_addr), .wdata1(counter_wdata),
        .rdata1(upd_counter), .addr2(pred_addr), .rdata2(pred_counter)
    );

    plru_state u_plru (
        .clk(clk), .arst_n(arst_n), .touch(touch), .touch_index(touch_index),
        .touch_way(touch_way), .clear(clear), .clear_index(clear_index),
        .victim_index(victim_index), .victim(victim)
    );

    btb_lookup u_lookup (
        .lookup(lookup), .ready(ready), .meta_row(lk_meta_row), .meta_index(lk_meta_index),
        .pred_addr(pred_addr), .target(pred_target), .counter(pred_counter),
        .response(response), .touch(touch), .touch_index(touch_index), .touch_way(touch_way)
    );

    btb_update u_update (
        .clk(clk), .arst_n(arst_n), .update(update), .meta_row(upd_meta_row),
        .meta_we(meta_we), .meta_index(upd_meta_index), .meta_wdata(meta_wdata),
        .ram_addr(upd_ram_addr), .counter_rd(upd_counter),
        .target_we(target_we), .target_wdata(target_wdata),
        .counter_we(counter_we), .counter_wdata(counter_wdata),
        .victim(victim), .victim_index(victim_index),
        .clear(clear), .clear_index(clear_index), .ready(ready)
    );

endmodule

// File: sim/branch_predictor_chk.sv
`timescale 1ns/1ps

module branch_predictor_chk (
    input logic clk,
    input logic arst_n,
    input bp_pkg::lookup_rsp_t response,
    input logic ready
);

    // count of failed assertions, read at the end of the run
    int unsigned fail_count = 0;

    // no hit during the sweep
    hit_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
        response.hit |-> ready)
    else begin
        fail_count++;
        $error("hit reported while ready low");
    end

    // target bus quiet on a miss
    miss_zero_target: assert property (@(posedge clk) disable iff (!arst_n)
        !response.hit |-> response.target == '0)
    else begin
        fail_count++;
        $error("nonzero target without a hit");
    end

    // sweep runs once per reset
    ready_stays: assert property (@(posedge clk) disable iff (!arst_n)
        ready |=> ready)
    else begin
        fail_count++;
        $error("ready fell after rising");
    end

    hit_has_source: assert property (@(posedge clk) disable iff (!arst_n)
        response.hit == (response.hit_pc | response.hit_pcp4))
    else begin
        fail_count++;
        $error("hit disagrees with hit_pc and hit_pcp4");
    end

endmodule

bind branch_predictor branch_predictor_chk i_chk (
    .clk(clk), .arst_n(arst_n), .response(response), .ready(ready)
);

// File: sim/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    logic clk;
    logic arst_n;
    bp_pkg::lookup_req_t lookup;
    bp_pkg::update_req_t update;
    bp_pkg::lookup_rsp_t response;
    logic ready;

    // mirror of the three tables and the replacement bits
    logic m_valid [bp_pkg::SET_NUM][bp_pkg::ASSOCIATIVITY];
    bp_pkg::tag_t m_tag [bp_pkg::SET_NUM][bp_pkg::ASSOCIATIVITY];
    bp_pkg::addr_t m_target [bp_pkg::SET_NUM][bp_pkg::ASSOCIATIVITY];
    bp_pkg::counter_t m_counter [bp_pkg::SET_NUM][bp_pkg::ASSOCIATIVITY];
    logic m_plru [bp_pkg::SET_NUM];

    int edge_count;
    int hit_count;
    int pcp4_count;
    logic [31:0] rng_state;
    logic [11:0] outcomes;

    branch_predictor i_dut (
        .clk(clk), .arst_n(arst_n), .lookup(lookup), .update(update),
        .response(response), .ready(ready)
    );

    always #4 clk = ~clk;

    // edges out of reset, sweep ends after SET_NUM of them
    always @(posedge clk) begin
        if (arst_n) begin
            edge_count <= edge_count + 1;
        end
    end

    // tag is pc[19:2], set is pc[7:4]
    function automatic bp_pkg::tag_t tag_field(bp_pkg::addr_t pc);
        return pc[19:2];
    endfunction

    function automatic bp_pkg::index_t set_field(bp_pkg::addr_t pc);
        return pc[7:4];
    endfunction

    function automatic logic match_way(bp_pkg::index_t idx, bp_pkg::tag_t tag,
                                       output bp_pkg::way_t way);
        logic found;
        found = 1'b0;
        way = '0;
        for (int i = 0; i < bp_pkg::ASSOCIATIVITY; i++) begin
            if (m_valid[idx][i] && m_tag[idx][i] == tag) begin
                found = 1'b1;
                way = bp_pkg::way_t'(i);
            end
        end
        return found;
    endfunction

    // pc entry first, else pc+4 searched in the pc's set
    function automatic logic lookup_way(bp_pkg::addr_t pc, output bp_pkg::way_t way,
                                        output logic via_pc);
        via_pc = match_way(set_field(pc), tag_field(pc), way);
        if (via_pc) begin
            return 1'b1;
        end
        return match_way(set_field(pc), tag_field(pc + 32'd4), way);
    endfunction

    function automatic bp_pkg::lookup_rsp_t ref_lookup(bp_pkg::addr_t pc, logic rdy);
        bp_pkg::lookup_rsp_t rsp;
        bp_pkg::way_t way;
        logic via_pc;
        rsp = '0;
        // nothing hits until the sweep is over
        if (rdy && lookup_way(pc, way, via_pc)) begin
            rsp.hit = 1'b1;
            rsp.hit_pc = via_pc;
            rsp.hit_pcp4 = ~via_pc;
            rsp.taken = m_counter[set_field(pc)][way][1];
            rsp.target = m_target[set_field(pc)][way];
        end
        return rsp;
    endfunction

    function automatic void ref_update(bp_pkg::update_req_t upd);
        bp_pkg::index_t idx;
        bp_pkg::way_t way;
        idx = set_field(upd.pc);
        if (!upd.valid) begin
            return;
        end
        if (match_way(idx, tag_field(upd.pc), way)) begin
            // saturating step, target left alone
            if (upd.taken && m_counter[idx][way] != 2'd3) begin
                m_counter[idx][way] = m_counter[idx][way] + 2'd1;
            end else if (!upd.taken && m_counter[idx][way] != 2'd0) begin
                m_counter[idx][way] = m_counter[idx][way] - 2'd1;
            end
        end else if (upd.taken) begin
            // victim named by the set's plru bit
            way = m_plru[idx];
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way] = tag_field(upd.pc);
            m_target[idx][way] = upd.dest;
            m_counter[idx][way] = 2'd3;
        end
    endfunction

    // table state right after the sweep
    function automatic void reset_model();
        for (int s = 0; s < bp_pkg::SET_NUM; s++) begin
            m_plru[s] = 1'b0;
            for (int w = 0; w < bp_pkg::ASSOCIATIVITY; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_target[s][w] = '0;
                m_counter[s][w] = 2'd3;
            end
        end
    endfunction

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // two sets, three upper tag values, any word
    function automatic bp_pkg::addr_t random_pc(logic [31:0] r);
        logic [31:0] hi;
        hi = 32'(r[9:8]) % 3;
        return 32'h0001_0000 | (hi << 8) | (32'(r[4]) << 4) | (32'(r[6:5]) << 2);
    endfunction

    task automatic check_rsp(bp_pkg::lookup_rsp_t got, bp_pkg::lookup_rsp_t exp);
        if (got !== exp) begin
            $display("FAIL response got %h expected %h at pc %h", got, exp, lookup.pc);
            $display("TESTS FAILED");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL ready got %h expected %h", got, exp);
            $display("TESTS FAILED");
            $fatal(1, "ready mismatch");
        end
    endtask

    // outputs settled mid cycle, model then takes the coming edge
    always @(negedge clk) begin : compare
        bp_pkg::lookup_rsp_t exp_rsp;
        bp_pkg::way_t way;
        logic via_pc;
        logic found;
        logic exp_ready;
        if (arst_n) begin
            exp_ready = (edge_count >= bp_pkg::SET_NUM);
            check_ready(ready, exp_ready);
            exp_rsp = ref_lookup(lookup.pc, exp_ready);
            check_rsp(response, exp_rsp);
            // hit way taken before the update rewrites the set
            found = lookup_way(lookup.pc, way, via_pc);
            if (exp_ready) begin
                ref_update(update);
                if (found) begin
                    m_plru[set_field(lookup.pc)] = ~way;
                end
            end
            hit_count += exp_rsp.hit;
            pcp4_count += exp_rsp.hit_pcp4;
        end
    end

    task automatic drive_cycle(bp_pkg::addr_t lk_pc, logic valid, bp_pkg::addr_t pc,
                               logic taken, bp_pkg::addr_t dest);
        @(posedge clk);
        #1;
        lookup.pc = lk_pc;
        update.valid = valid;
        update.pc = pc;
        update.taken = taken;
        update.dest = dest;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1 && n < 4 * bp_pkg::SET_NUM) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("timeout, ready never rose after reset");
            $display("TESTS FAILED");
            $fatal(1, "ready timeout");
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        lookup = '0;
        update = '0;
        edge_count = 0;
        hit_count = 0;
        pcp4_count = 0;
        rng_state = 32'd66;
        outcomes = 12'b1010_1111_0000;
        reset_model();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // sweep running, this update must be dropped
        drive_cycle(32'h0000_1000, 1'b1, 32'h0000_1000, 1'b1, 32'h0000_8000);
        drive_cycle(32'h0000_1000, 1'b0, '0, 1'b0, '0);
        wait_ready();
        drive_cycle(32'h0000_1000, 1'b0, '0, 1'b0, '0);

        // every set reads back invalid once the sweep is done
        for (int s = 0; s < bp_pkg::SET_NUM; s++) begin
            drive_cycle(32'(s) << 4, 1'b0, '0, 1'b0, '0);
        end

        // taken miss allocates, next lookup hits
        drive_cycle(32'h0000_1000, 1'b1, 32'h0000_1000, 1'b1, 32'h0000_8000);
        drive_cycle(32'h0000_1000, 1'b0, '0, 1'b0, '0);

        // counter walks down, saturates, walks up again
        for (int i = 0; i < 12; i++) begin
            drive_cycle(32'h0000_1000, 1'b1, 32'h0000_1000, outcomes[i], 32'h0000_9000);
        end
        drive_cycle(32'h0000_1000, 1'b0, '0, 1'b0, '0);

        // not taken miss leaves the table alone
        drive_cycle(32'h0000_2210, 1'b1, 32'h0000_2210, 1'b0, 32'h0000_7000);
        drive_cycle(32'h0000_2210, 1'b0, '0, 1'b0, '0);

        // pc+4 stored, its hit points the plru at the other way
        drive_cycle(32'h0000_2100, 1'b1, 32'h0000_2104, 1'b1, 32'h0000_3000);
        drive_cycle(32'h0000_2100, 1'b0, '0, 1'b0, '0);
        // pc lands beside the pc+4 entry and wins
        drive_cycle(32'h0000_2100, 1'b1, 32'h0000_2100, 1'b1, 32'h0000_4000);
        drive_cycle(32'h0000_2100, 1'b0, '0, 1'b0, '0);

        // random traffic on two sets forces evictions
        repeat (300) begin
            drive_cycle(random_pc(next_random()), 1'(next_random() >> 31),
                        random_pc(next_random()), 1'(next_random() >> 31),
                        next_random() & 32'hffff_fffc);
        end
        drive_cycle('0, 1'b0, '0, 1'b0, '0);
        @(negedge clk);
        #1;
        if (hit_count > 0 && pcp4_count > 0 && i_dut.i_chk.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("no hits seen, no pc+4 hits seen, or an assertion failed");
            $display("TESTS FAILED");
            $fatal(1, "run failed");
        end
    end

endmodule

// File: vlog.f
source/bp_pkg.sv
source/lutram_dual_port.sv
source/plru_state.sv
source/btb_lookup.sv
source/btb_update.sv
source/branch_predictor.sv
sim/branch_predictor_chk.sv
sim/tb_branch_predictor.sv
